// ==== hdl/cart_config.svh ====
`ifndef CART_CONFIG_SVH
`define CART_CONFIG_SVH

// shared PRG/CHR memory address width
`define ADDR_BITS 23

// mapper slots behind the mux
`define MAP_CNT 4

// host register map
`define REG_MAPPER 4'd0
`define REG_LOADER 4'd1

`endif

// ==== hdl/cart_pkg.sv ====
`include "cart_config.svh"

package cart_pkg;

    // ************************************************************************
    // plain widths
    // ************************************************************************

    typedef logic [15:0] cpu_addr_t;
    typedef logic [13:0] ppu_addr_t;
    typedef logic [7:0] byte_t;
    typedef logic [`ADDR_BITS-1:0] mem_addr_t;  // shared PRG/CHR memory

    // ************************************************************************
    // console buses
    // ************************************************************************

    // CPU side, sampled on m2
    typedef struct packed {
        cpu_addr_t addr;
        logic rw;  // 1 = read
        byte_t data;  // write data
    } cpu_bus_t;

    // PPU side
    typedef struct packed {
        ppu_addr_t addr;
        logic rd;
        logic wr;
    } ppu_bus_t;

endpackage

// ==== hdl/mapper_pkg.sv ====
package mapper_pkg;

    // mapper select, one slot each
    typedef logic [1:0] mapper_id_t;

    localparam mapper_id_t MAP_NROM = 2'd0;
    localparam mapper_id_t MAP_UXROM = 2'd1;
    localparam mapper_id_t MAP_CNROM = 2'd2;
    localparam mapper_id_t MAP_MMC1 = 2'd3;

    // log2 of PRG size in bytes
    typedef logic [4:0] prg_size_t;

    typedef struct packed {
        logic reserved;
        logic mirror_v;  // hard mirroring, 1 = vertical
        prg_size_t prg_size;
    } map_args_t;

    // one mapper's view of memory and CIRAM
    typedef struct packed {
        cart_pkg::mem_addr_t prg_addr;
        logic prg_oe;
        cart_pkg::mem_addr_t chr_addr;
        logic chr_oe;
        logic chr_we;
        logic ciram_a10;
        logic ciram_ce;
    } map_out_t;

endpackage

// ==== hdl/map_regs.sv ====
`timescale 1ns/1ps
`include "cart_config.svh"

module map_regs (
    input logic m2,
    input logic async_reset,
    input logic [31:0] wr_reg,
    input logic [3:0] wr_reg_addr,
    input logic wr_reg_changed,
    output mapper_pkg::mapper_id_t select,
    output mapper_pkg::map_args_t map_args
);
    import mapper_pkg::*;

    logic [2:0] chg_sync;
    logic chg_seen;
    logic [31:0] loader_args;

    // toggle crosses from host domain, stage 2 vs 3 is the edge detect
    assign chg_seen = chg_sync[1] != chg_sync[2];

    always_ff @(posedge m2 or posedge async_reset) begin
        if (async_reset) begin
            chg_sync <= '0;
            select <= MAP_NROM;
            map_args <= '0;
        end else begin
            chg_sync <= {chg_sync[1:0], wr_reg_changed};
            if (chg_seen && wr_reg_addr == `REG_MAPPER) begin
                {map_args, select} <= wr_reg[8:0];
            end
        end
    end

    // kept for the loader, which is not built here
    always_ff @(posedge m2) begin
        if (chg_seen && wr_reg_addr == `REG_LOADER) begin
            loader_args <= wr_reg;
        end
    end

endmodule

// ==== hdl/map_discrete.sv ====
`timescale 1ns/1ps

// NROM / UxROM / CNROM, differing only in what the bank latch drives
module map_discrete #(
    parameter int KIND = 0  // 0 NROM, 1 UxROM, 2 CNROM
) (
    input logic m2,
    input logic rst,
    input cart_pkg::cpu_bus_t cpu,
    input cart_pkg::ppu_bus_t ppu,
    input logic mirror_v,
    output mapper_pkg::map_out_t map_out
);
    import cart_pkg::*;
    import mapper_pkg::*;

    byte_t bank;
    logic cpu_wr;
    byte_t prg_page;  // 16 KB page for UxROM

    assign cpu_wr = !cpu.rw && cpu.addr[15];

    always_ff @(posedge m2 or posedge rst) begin
        if (rst) begin
            bank <= '0;
        end else if (KIND != 0 && cpu_wr) begin
            bank <= cpu.data;
        end
    end

    // top page fixed, the size mask in the mux cuts it to the last one
    assign prg_page = cpu.addr[14] ? 8'hff : bank;

    always_comb begin
        case (KIND)
            1: begin
                map_out.prg_addr = mem_addr_t'({prg_page, cpu.addr[13:0]});
                map_out.chr_addr = mem_addr_t'(ppu.addr[12:0]);
            end
            2: begin
                map_out.prg_addr = mem_addr_t'(cpu.addr[14:0]);
                map_out.chr_addr = mem_addr_t'({bank, ppu.addr[12:0]});
            end
            default: begin
                map_out.prg_addr = mem_addr_t'(cpu.addr[14:0]);
                map_out.chr_addr = mem_addr_t'(ppu.addr[12:0]);
            end
        endcase
    end

    assign map_out.prg_oe = cpu.rw && cpu.addr[15];
    assign map_out.chr_oe = ppu.rd && !ppu.addr[13];
    assign map_out.chr_we = (KIND == 1) && ppu.wr && !ppu.addr[13];  // CHR RAM on UxROM only
    assign map_out.ciram_a10 = mirror_v ? ppu.addr[10] : ppu.addr[11];
    assign map_out.ciram_ce = ppu.addr[13];

endmodule

// ==== hdl/map_mmc1.sv ====
`timescale 1ns/1ps

module map_mmc1 (
    input logic m2,
    input logic rst,
    input cart_pkg::cpu_bus_t cpu,
    input cart_pkg::ppu_bus_t ppu,
    output mapper_pkg::map_out_t map_out
);
    import cart_pkg::*;
    import mapper_pkg::*;

    logic [4:0] shift;
    logic [2:0] wr_cnt;
    logic [4:0] value;  // assembled on the fifth write
    logic [4:0] control;
    logic [4:0] chr0;
    logic [4:0] chr1;
    logic [3:0] prg;
    logic cpu_wr;
    logic [3:0] prg_page;
    logic [4:0] chr_page;

    assign cpu_wr = !cpu.rw && cpu.addr[15];
    assign value = {cpu.data[0], shift[4:1]};  // LSB first

    // ************************************************************************
    // serial loader
    // ************************************************************************

    always_ff @(posedge m2 or posedge rst) begin
        if (rst) begin
            shift <= '0;
            wr_cnt <= '0;
            control <= '0;
            chr0 <= '0;
            chr1 <= '0;
            prg <= '0;
        end else if (cpu_wr) begin
            if (cpu.data[7]) begin  // loader reset
                shift <= '0;
                wr_cnt <= '0;
                control[3:2] <= 2'b11;
            end else if (wr_cnt == 3'd4) begin
                shift <= '0;
                wr_cnt <= '0;
                case (cpu.addr[14:13])
                    2'd0: control <= value;
                    2'd1: chr0 <= value;
                    2'd2: chr1 <= value;
                    default: prg <= value[3:0];
                endcase
            end else begin
                shift <= value;
                wr_cnt <= wr_cnt + 3'd1;
            end
        end
    end

    // ************************************************************************
    // address decode
    // ************************************************************************

    always_comb begin
        case (control[3:2])
            2'd2: prg_page = cpu.addr[14] ? prg : 4'h0;  // first fixed
            2'd3: prg_page = cpu.addr[14] ? 4'hf : prg;  // last fixed
            default: prg_page = {prg[3:1], cpu.addr[14]};  // 32 KB
        endcase
    end

    always_comb begin
        if (control[4]) begin  // two 4 KB banks
            chr_page = ppu.addr[12] ? chr1 : chr0;
        end else begin
            chr_page = {chr0[4:1], ppu.addr[12]};
        end
    end

    assign map_out.prg_addr = mem_addr_t'({prg_page, cpu.addr[13:0]});
    assign map_out.chr_addr = mem_addr_t'({chr_page, ppu.addr[11:0]});
    assign map_out.prg_oe = cpu.rw && cpu.addr[15];
    assign map_out.chr_oe = ppu.rd && !ppu.addr[13];
    assign map_out.chr_we = ppu.wr && !ppu.addr[13];

    always_comb begin
        case (control[1:0])
            2'd0: map_out.ciram_a10 = 1'b0;
            2'd1: map_out.ciram_a10 = 1'b1;
            2'd2: map_out.ciram_a10 = ppu.addr[10];  // vertical
            default: map_out.ciram_a10 = ppu.addr[11];  // horizontal
        endcase
    end

    assign map_out.ciram_ce = ppu.addr[13];

endmodule

// ==== hdl/map_mux.sv ====
`timescale 1ns/1ps
`include "cart_config.svh"

module map_mux (
    input mapper_pkg::mapper_id_t select,
    input mapper_pkg::map_args_t map_args,
    input mapper_pkg::map_out_t slots [`MAP_CNT],
    output logic [`MAP_CNT-1:0] slot_rst,
    output cart_pkg::mem_addr_t prg_addr,
    output logic prg_rd,
    output logic cpu_oe,
    output cart_pkg::mem_addr_t chr_addr,
    output logic chr_rd,
    output logic chr_we,
    output logic ciram_a10,
    output logic ciram_ce
);
    import cart_pkg::*;
    import mapper_pkg::*;

    map_out_t sel;
    mem_addr_t prg_mask;
    mem_addr_t chr_off;

    // unselected mappers sit in reset
    for (genvar n = 0; n < `MAP_CNT; n++) begin : g_rst
        assign slot_rst[n] = (select != mapper_id_t'(n));
    end

    assign sel = slots[select];

    // ************************************************************************
    // memory layout, PRG at 0 and CHR right above it
    // ************************************************************************

    assign prg_mask = (mem_addr_t'(1) << map_args.prg_size) - mem_addr_t'(1);
    assign chr_off = (map_args.prg_size == '0) ? '0
                                               : (mem_addr_t'(1) << map_args.prg_size);

    assign prg_addr = sel.prg_addr & prg_mask;
    assign chr_addr = sel.chr_addr | chr_off;

    assign prg_rd = sel.prg_oe;
    assign cpu_oe = sel.prg_oe;
    assign chr_rd = sel.chr_oe;
    assign chr_we = sel.chr_we;

    assign ciram_a10 = sel.ciram_a10;
    assign ciram_ce = sel.ciram_ce;

endmodule

// ==== hdl/cart_top.sv ====
`timescale 1ns/1ps
`include "cart_config.svh"

module cart_top (
    input logic m2,
    input logic async_reset,
    input cart_pkg::cpu_bus_t cpu,
    input cart_pkg::ppu_bus_t ppu,
    input logic [31:0] wr_reg,
    input logic [3:0] wr_reg_addr,
    input logic wr_reg_changed,
    output cart_pkg::mem_addr_t prg_addr,
    output logic prg_rd,
    output logic cpu_oe,
    output cart_pkg::mem_addr_t chr_addr,
    output logic chr_rd,
    output logic chr_we,
    output logic ciram_a10,
    output logic ciram_ce
);
    import mapper_pkg::*;

    mapper_id_t select;
    map_args_t map_args;
    map_out_t slots [`MAP_CNT];
    logic [`MAP_CNT-1:0] slot_rst;

    map_regs u_regs (
        .m2(m2),
        .async_reset(async_reset),
        .wr_reg(wr_reg),
        .wr_reg_addr(wr_reg_addr),
        .wr_reg_changed(wr_reg_changed),
        .select(select),
        .map_args(map_args)
    );

    // ************************************************************************
    // mapper slots, index = mapper id
    // ************************************************************************

    map_discrete #(.KIND(0)) u_nrom (
        .m2(m2),
        .rst(slot_rst[MAP_NROM]),
        .cpu(cpu),
        .ppu(ppu),
        .mirror_v(map_args.mirror_v),
        .map_out(slots[MAP_NROM])
    );

    map_discrete #(.KIND(1)) u_uxrom (
        .m2(m2),
        .rst(slot_rst[MAP_UXROM]),
        .cpu(cpu),
        .ppu(ppu),
        .mirror_v(map_args.mirror_v),
        .map_out(slots[MAP_UXROM])
    );

    map_discrete #(.KIND(2)) u_cnrom (
        .m2(m2),
        .rst(slot_rst[MAP_CNROM]),
        .cpu(cpu),
        .ppu(ppu),
        .mirror_v(map_args.mirror_v),
        .map_out(slots[MAP_CNROM])
    );

    map_mmc1 u_mmc1 (
        .m2(m2),
        .rst(slot_rst[MAP_MMC1]),
        .cpu(cpu),
        .ppu(ppu),
        .map_out(slots[MAP_MMC1])  // mirroring set by software
    );

    map_mux u_mux (
        .select(select),
        .map_args(map_args),
        .slots(slots),
        .slot_rst(slot_rst),
        .prg_addr(prg_addr),
        .prg_rd(prg_rd),
        .cpu_oe(cpu_oe),
        .chr_addr(chr_addr),
        .chr_rd(chr_rd),
        .chr_we(chr_we),
        .ciram_a10(ciram_a10),
        .ciram_ce(ciram_ce)
    );

endmodule

// ==== tb/cart_checker.sv ====
`timescale 1ns/1ps

module cart_checker (
    input logic m2,
    input logic [7:0] test_id,
    input logic chk,
    input logic done,
    input cart_pkg::mem_addr_t exp_prg,
    input cart_pkg::mem_addr_t exp_chr,
    input logic exp_oe,
    input logic exp_we,
    input logic exp_a10,
    input cart_pkg::ppu_bus_t ppu,
    input cart_pkg::mem_addr_t prg_addr,
    input cart_pkg::mem_addr_t chr_addr,
    input logic prg_rd,
    input logic cpu_oe,
    input logic chr_rd,
    input logic chr_we,
    input logic ciram_a10,
    input logic ciram_ce,
    output int tests_run,
    output int tests_failed,
    output int mismatches,
    output logic finished
);
    logic [7:0] cur_test;
    int test_errs;
    int test_checks;
    logic exp_chr_rd;
    logic exp_ce;

    // pattern tables sit below 2000, nametables from 2000 up
    assign exp_chr_rd = ppu.rd && (ppu.addr < 14'h2000);
    assign exp_ce = (ppu.addr >= 14'h2000);

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR test %0d %s got %h expected %h", cur_test, name, got, exp);
            mismatches++;
            test_errs++;
        end
    endtask

    task automatic close_test();
        if (cur_test != 8'd0) begin
            tests_run++;
            if (test_errs != 0) begin
                tests_failed++;
                $display("test %0d failed, %0d mismatches", cur_test, test_errs);
            end else begin
                $display("test %0d passed, %0d steps checked", cur_test, test_checks);
            end
        end
        test_errs = 0;
        test_checks = 0;
    endtask

    initial begin
        tests_run = 0;
        tests_failed = 0;
        mismatches = 0;
        finished = 1'b0;
        cur_test = 8'd0;
        test_errs = 0;
        test_checks = 0;
    end

    // sampled before this edge's flop updates land
    always @(posedge m2) begin
        if (!finished) begin
            if (done) begin
                close_test();
                finished = 1'b1;
            end else begin
                if (test_id != cur_test) begin
                    close_test();
                    cur_test = test_id;
                end
                if (chk) begin
                    test_checks++;
                    compare_value("prg_addr", 32'(prg_addr), 32'(exp_prg));
                    compare_value("chr_addr", 32'(chr_addr), 32'(exp_chr));
                    compare_value("cpu_oe", 32'(cpu_oe), 32'(exp_oe));
                    compare_value("prg_rd", 32'(prg_rd), 32'(exp_oe));  // same strobe
                    compare_value("chr_rd", 32'(chr_rd), 32'(exp_chr_rd));
                    compare_value("chr_we", 32'(chr_we), 32'(exp_we));
                    compare_value("ciram_a10", 32'(ciram_a10), 32'(exp_a10));
                    compare_value("ciram_ce", 32'(ciram_ce), 32'(exp_ce));
                end
            end
        end
    end

endmodule

// ==== tb/cart_sva.sv ====
`timescale 1ns/1ps

module cart_sva (
    input logic m2,
    input logic async_reset,
    input logic chr_we,
    input logic chr_rd,
    input logic cpu_oe,
    input logic cpu_a15
);
    int failures = 0;  // read by the testbench

    // one CHR access direction at a time
    chr_one_way: assert property (@(posedge m2) disable iff (async_reset)
        !(chr_we && chr_rd))
        else begin
            $error("chr_we and chr_rd high together");
            failures++;
        end

    oe_in_rom: assert property (@(posedge m2) disable iff (async_reset)
        cpu_oe |-> cpu_a15)
        else begin
            $error("cpu_oe high outside the 8000-FFFF window");
            failures++;
        end

endmodule

bind cart_top cart_sva u_sva (
    .m2(m2),
    .async_reset(async_reset),
    .chr_we(chr_we),
    .chr_rd(chr_rd),
    .cpu_oe(cpu_oe),
    .cpu_a15(cpu.addr[15])
);

// ==== tb/cart_tb.sv ====
`timescale 1ns/1ps

module cart_tb;
    import cart_pkg::*;

    // one line of the stimulus file
    typedef struct packed {
        logic [7:0] test;
        logic host;
        logic [3:0] reg_addr;
        logic [31:0] word;
        cpu_bus_t cpu;
        ppu_bus_t ppu;
        logic chk;
        mem_addr_t prg;
        mem_addr_t chr;
        logic oe;
        logic we;
        logic a10;
    } step_t;

    logic m2 = 1'b0;
    logic async_reset;
    cpu_bus_t cpu;
    ppu_bus_t ppu;
    logic [31:0] wr_reg;
    logic [3:0] wr_reg_addr;
    logic wr_reg_changed;
    mem_addr_t prg_addr;
    mem_addr_t chr_addr;
    logic prg_rd;
    logic cpu_oe;
    logic chr_rd;
    logic chr_we;
    logic ciram_a10;
    logic ciram_ce;

    step_t cur;  // expected values for the checker
    step_t steps[$];
    logic done;
    logic finished;
    int tests_run;
    int tests_failed;
    int mismatches;
    int bad_lines;
    longint timeout_ns;

    always #50 m2 = ~m2;

    cart_top UUT (
        .m2(m2),
        .async_reset(async_reset),
        .cpu(cpu),
        .ppu(ppu),
        .wr_reg(wr_reg),
        .wr_reg_addr(wr_reg_addr),
        .wr_reg_changed(wr_reg_changed),
        .prg_addr(prg_addr),
        .prg_rd(prg_rd),
        .cpu_oe(cpu_oe),
        .chr_addr(chr_addr),
        .chr_rd(chr_rd),
        .chr_we(chr_we),
        .ciram_a10(ciram_a10),
        .ciram_ce(ciram_ce)
    );

    cart_checker u_check (
        .m2(m2),
        .test_id(cur.test),
        .chk(cur.chk),
        .done(done),
        .exp_prg(cur.prg),
        .exp_chr(cur.chr),
        .exp_oe(cur.oe),
        .exp_we(cur.we),
        .exp_a10(cur.a10),
        .ppu(ppu),
        .prg_addr(prg_addr),
        .chr_addr(chr_addr),
        .prg_rd(prg_rd),
        .cpu_oe(cpu_oe),
        .chr_rd(chr_rd),
        .chr_we(chr_we),
        .ciram_a10(ciram_a10),
        .ciram_ce(ciram_ce),
        .tests_run(tests_run),
        .tests_failed(tests_failed),
        .mismatches(mismatches),
        .finished(finished)
    );

    // ************************************************************************
    // stimulus file
    // ************************************************************************

    task automatic read_steps();
        int fd;
        int n;
        string line;
        logic [31:0] f [16];
        step_t s;
        fd = $fopen("tb/cart_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tb/cart_input.txt");
            bad_lines++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.substr(0, 1) == "//") continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                        f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
            if (n != 16) begin
                $display("stimulus line has %0d fields instead of 16: %s", n, line);
                bad_lines++;
                continue;
            end
            s.test = f[0][7:0];
            s.host = f[1][0];
            s.reg_addr = f[2][3:0];
            s.word = f[3];
            s.cpu.addr = f[4][15:0];
            s.cpu.rw = f[5][0];
            s.cpu.data = f[6][7:0];
            s.ppu.addr = f[7][13:0];
            s.ppu.rd = f[8][0];
            s.ppu.wr = f[9][0];
            s.chk = f[10][0];
            s.prg = mem_addr_t'(f[11]);
            s.chr = mem_addr_t'(f[12]);
            s.oe = f[13][0];
            s.we = f[14][0];
            s.a10 = f[15][0];
            steps.push_back(s);
        end
        $fclose(fd);
    endtask

    // reads below the cartridge window where no mapper reacts
    task automatic drive_filler();
        cpu.addr = cpu_addr_t'($urandom()) & 16'h7fff;
        cpu.rw = 1'b1;
        cpu.data = '0;
        ppu = '0;
    endtask

    task automatic apply_step(input step_t s);
        cur = s;
        if (s.host) begin
            wr_reg = s.word;
            wr_reg_addr = s.reg_addr;
            wr_reg_changed = !wr_reg_changed;
            drive_filler();
            // select settles on the third rising edge
            repeat (4) begin
                @(negedge m2);
                drive_filler();
            end
        end else begin
            cpu = s.cpu;
            ppu = s.ppu;
        end
    endtask

    initial begin
        void'($urandom(32'h8338));
        async_reset = 1'b1;
        cpu = '0;
        cpu.rw = 1'b1;
        ppu = '0;
        wr_reg = '0;
        wr_reg_addr = '0;
        wr_reg_changed = 1'b0;
        cur = '0;
        done = 1'b0;
        bad_lines = 0;
        timeout_ns = 0;
        read_steps();
        // five cycles per host step plus reset and wind-down
        timeout_ns = (longint'(steps.size()) * 5 + 10) * 100;
        repeat (3) @(negedge m2);
        async_reset = 1'b0;
        foreach (steps[i]) begin
            @(negedge m2);
            apply_step(steps[i]);
        end
        @(negedge m2);
        cur.chk = 1'b0;
        done = 1'b1;
        wait (finished);
        $display("%0d tests, %0d failed, %0d mismatches, %0d assertion failures, %0d bad lines",
                 tests_run, tests_failed, mismatches, UUT.u_sva.failures, bad_lines);
        if (tests_run > 0 && tests_failed == 0 && mismatches == 0 &&
            bad_lines == 0 && UUT.u_sva.failures == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (timeout_ns > 0);
        #(timeout_ns);
        $display("timeout, the stimulus did not finish within %0d ns", timeout_ns);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== tb/cart_input.txt ====
// test host reg word caddr rw cdata paddr rd wr chk exp_prg exp_chr exp_oe exp_we exp_a10
// host 1 = register write, then a four cycle wait; chk 0 = outputs not compared
1 0 0 00000000 8000 1 00 0123 1 0 1 000000 000123 1 0 0
1 0 0 00000000 0000 1 00 2800 0 0 1 000000 000800 0 0 1
2 1 0 0000003c 0000 1 00 0000 0 0 0 000000 000000 0 0 0
2 0 0 00000000 c123 1 00 0456 1 0 1 004123 008456 1 0 0
2 0 0 00000000 8000 1 00 1c00 0 1 1 000000 009c00 1 0 1
3 1 0 00000045 0000 1 00 0000 0 0 0 000000 000000 0 0 0
3 0 0 00000000 8000 0 02 0000 0 0 0 000000 000000 0 0 0
3 0 0 00000000 8005 1 00 0010 1 0 1 008005 020010 1 0 0
3 0 0 00000000 fffc 1 00 0010 1 0 1 01fffc 020010 1 0 0
3 0 0 00000000 0000 1 00 0345 0 1 1 008000 020345 0 1 0
4 1 0 000000be 0000 1 00 0000 0 0 0 000000 000000 0 0 0
4 0 0 00000000 8000 0 03 0000 0 0 0 000000 000000 0 0 0
4 0 0 00000000 8010 1 00 0400 1 0 1 000010 00e400 1 0 1
4 0 0 00000000 0000 1 00 2800 0 0 1 000000 00e800 0 0 0
5 1 0 0000004b 0000 1 00 0000 0 0 0 000000 000000 0 0 0
5 0 0 00000000 e000 0 01 0100 1 0 0 000000 000000 0 0 0
5 0 0 00000000 e000 0 00 0100 1 0 0 000000 000000 0 0 0
5 0 0 00000000 e000 0 01 0100 1 0 0 000000 000000 0 0 0
5 0 0 00000000 e000 0 00 0100 1 0 0 000000 000000 0 0 0
5 0 0 00000000 e000 0 00 0100 1 0 0 000000 000000 0 0 0
5 0 0 00000000 8000 1 00 0100 1 0 1 010000 040100 1 0 0
5 0 0 00000000 c001 1 00 0100 1 0 1 014001 040100 1 0 0
5 0 0 00000000 e000 0 01 0100 1 0 0 000000 000000 0 0 0
5 0 0 00000000 e000 0 01 0100 1 0 0 000000 000000 0 0 0
5 0 0 00000000 8000 0 80 0100 1 0 0 000000 000000 0 0 0
5 0 0 00000000 8000 1 00 0100 1 0 1 014000 040100 1 0 0
5 0 0 00000000 c000 1 00 0100 1 0 1 03c000 040100 1 0 0
5 0 0 00000000 e000 0 00 0100 1 0 0 000000 000000 0 0 0
5 0 0 00000000 e000 0 01 0100 1 0 0 000000 000000 0 0 0
5 0 0 00000000 e000 0 00 0100 1 0 0 000000 000000 0 0 0
5 0 0 00000000 e000 0 00 0100 1 0 0 000000 000000 0 0 0
5 0 0 00000000 e000 0 00 0100 1 0 0 000000 000000 0 0 0
5 0 0 00000000 8000 1 00 0100 1 0 1 008000 040100 1 0 0
5 0 0 00000000 c000 1 00 0100 1 0 1 03c000 040100 1 0 0
6 1 0 0000003c 0000 1 00 0000 0 0 0 000000 000000 0 0 0
6 0 0 00000000 c123 1 00 0456 1 0 1 004123 008456 1 0 0
6 1 0 0000004b 0000 1 00 0000 0 0 0 000000 000000 0 0 0
6 1 1 ffffffff 0000 1 00 0000 0 0 0 000000 000000 0 0 0
6 0 0 00000000 c001 1 00 0100 1 0 1 004001 040100 1 0 0
6 0 0 00000000 8000 1 00 0100 1 0 1 000000 040100 1 0 0

// ==== flist.f ====
+incdir+hdl
hdl/cart_pkg.sv
hdl/mapper_pkg.sv
hdl/map_regs.sv
hdl/map_discrete.sv
hdl/map_mmc1.sv
hdl/map_mux.sv
hdl/cart_top.sv
tb/cart_checker.sv
tb/cart_sva.sv
tb/cart_tb.sv

// ==== Bender.yml ====
package:
  name: cart_mapper

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cart_pkg.sv
      - hdl/mapper_pkg.sv
      - hdl/map_regs.sv
      - hdl/map_discrete.sv
      - hdl/map_mmc1.sv
      - hdl/map_mux.sv
      - hdl/cart_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/cart_checker.sv
      - tb/cart_sva.sv
      - tb/cart_tb.sv
